// File: Makefile
# Verilator build and run of the registration testbench

VERILATOR ?= verilator
TOP       ?= registration_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail if the log reports errors"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1; rc=$$?; \
	cat $(LOG); \
	if grep -q "ERRORS FOUND" $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi; \
	exit $$rc

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
+incdir+rtl
rtl/tracker_pkg.sv
rtl/feature_scoreboard.sv
rtl/scan_sequencer.sv
rtl/lane_distance_pe.sv
rtl/match_selector.sv
rtl/registration_top.sv
dv/registration_tb.sv

// File: dv/registration_tb.sv
`timescale 1ns/1ns
`include "tracker_params.svh"

module registration_tb;

	import tracker_pkg::*;

	// --------------------
	// DUT signals
	// --------------------

	logic     clk;
	logic     reset_N;
	logic     det_valid;
	feature_t det_feature;
	logic     ready_new_frame;
	logic     res_valid;
	row_t     res_id;
	logic     res_new;
	logic     res_drop;
	score_t   res_score;
	logic     det_overrun;

	// expected result of the detection in flight
	row_t     exp_id;
	bit       exp_new;
	bit       exp_drop;
	score_t   exp_score;
	int       exp_lat;
	int       strobe_cycle;
	bit       pending = 1'b0;

	// strobe sent while busy, and its registered copy
	bit       ovr_strobe = 1'b0;
	bit       ovr_exp = 1'b0;
	int       cycle = 0;
	int       mismatch_errs = 0;
	int       other_errs = 0;

	// model of the table
	feature_t mdl_rows [`MAX_ROWS];
	int       mdl_count;

	registration_top uut (
		.clk             (clk),
		.reset_N         (reset_N),
		.det_valid       (det_valid),
		.det_feature     (det_feature),
		.ready_new_frame (ready_new_frame),
		.res_valid       (res_valid),
		.res_id          (res_id),
		.res_new         (res_new),
		.res_drop        (res_drop),
		.res_score       (res_score),
		.det_overrun     (det_overrun)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle   <= cycle + 1;
		ovr_exp <= ovr_strobe;
	end

	// --------------------
	// checks
	// --------------------

	// no result unless a detection is in flight
	a_quiet: assert property (@(posedge clk) disable iff (!reset_N) !pending |-> !res_valid)
		else begin
			other_errs++;
			$display("res_valid raised at %0t with no detection pending", $time);
		end

	a_latency: assert property (@(posedge clk) disable iff (!reset_N)
		res_valid |-> ((cycle - strobe_cycle) == exp_lat))
		else begin
			mismatch_errs++;
			$display("mismatch at %0t: res_valid latency dut=%0d model=%0d",
				$time, $sampled(cycle) - strobe_cycle, exp_lat);
		end

	// id on a drop is not defined
	a_id: assert property (@(posedge clk) disable iff (!reset_N)
		(res_valid && !exp_drop) |-> (res_id == exp_id))
		else begin
			mismatch_errs++;
			$display("mismatch at %0t: res_id dut=%0d model=%0d", $time, $sampled(res_id), exp_id);
		end

	a_new: assert property (@(posedge clk) disable iff (!reset_N) res_valid |-> (res_new == exp_new))
		else begin
			mismatch_errs++;
			$display("mismatch at %0t: res_new dut=%0b model=%0b", $time, $sampled(res_new), exp_new);
		end

	a_drop: assert property (@(posedge clk) disable iff (!reset_N)
		res_valid |-> (res_drop == exp_drop))
		else begin
			mismatch_errs++;
			$display("mismatch at %0t: res_drop dut=%0b model=%0b",
				$time, $sampled(res_drop), exp_drop);
		end

	a_score: assert property (@(posedge clk) disable iff (!reset_N)
		res_valid |-> (res_score == exp_score))
		else begin
			mismatch_errs++;
			$display("mismatch at %0t: res_score dut=%0d model=%0d",
				$time, $sampled(res_score), exp_score);
		end

	// overrun one cycle after a busy strobe, never otherwise
	a_overrun: assert property (@(posedge clk) disable iff (!reset_N) det_overrun == ovr_exp)
		else begin
			mismatch_errs++;
			$display("mismatch at %0t: det_overrun dut=%0b model=%0b",
				$time, $sampled(det_overrun), ovr_exp);
		end

	// --------------------
	// reference model
	// --------------------

	function automatic int lane_l1(input feature_t a, input feature_t b);
		int sum;
		int d;
		sum = 0;
		for (int i = 0; i < `FEAT_LANES; i++) begin
			d = int'(a[i]) - int'(b[i]);
			if (d < 0) d = -d;
			sum += d;
		end
		return sum;
	endfunction

	function automatic void model_clear();
		for (int r = 0; r < `MAX_ROWS; r++) mdl_rows[r] = '0;
		mdl_count = 0;
	endfunction

	// predicts the result and updates the model table
	function automatic void model_predict(input feature_t feat);
		int best;
		int best_row;
		int d;
		best = -1;
		best_row = 0;
		for (int r = 0; r < mdl_count; r++) begin
			d = lane_l1(feat, mdl_rows[r]);
			// strictly smaller, lowest row keeps a tie
			if (best < 0 || d < best) begin
				best = d;
				best_row = r;
			end
		end
		exp_drop = 1'b0;
		if (mdl_count == 0) begin
			// empty table, no scan at all
			exp_lat = 1;
			exp_score = '0;
			exp_id = '0;
			exp_new = 1'b1;
			mdl_rows[0] = feat;
			mdl_count = 1;
		end else begin
			exp_lat = mdl_count + 3;
			exp_score = score_t'(best);
			if (best <= `MATCH_THRESH) begin
				exp_id = row_t'(best_row);
				exp_new = 1'b0;
				mdl_rows[best_row] = feat;
			end else if (mdl_count == `MAX_ROWS) begin
				exp_new = 1'b0;
				exp_drop = 1'b1;
			end else begin
				exp_id = row_t'(mdl_count);
				exp_new = 1'b1;
				mdl_rows[mdl_count] = feat;
				mdl_count++;
			end
		end
	endfunction

	// lanes moved by at most 5, sum stays under the threshold
	function automatic feature_t near_copy(input feature_t base);
		feature_t f;
		int v;
		f = base;
		for (int i = 0; i < `FEAT_LANES; i++) begin
			v = int'(base[i]) + int'($urandom_range(0, 10)) - 5;
			if (v < 0) v = 0;
			if (v > 255) v = 255;
			f[i] = lane_t'(v);
		end
		return f;
	endfunction

	// --------------------
	// stimulus tasks
	// --------------------

	// ovr_at > 0 sends a busy strobe that many cycles after the detection
	task automatic detect(input feature_t feat, input int ovr_at);
		int waited;
		bit seen;
		@(negedge clk);
		model_predict(feat);
		det_feature = feat;
		det_valid = 1'b1;
		pending = 1'b1;
		strobe_cycle = cycle;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < 40) begin
			@(negedge clk);
			det_valid = 1'b0;
			ovr_strobe = 1'b0;
			waited++;
			if (res_valid) begin
				seen = 1'b1;
			end else if (waited == ovr_at) begin
				det_feature = feature_t'($urandom());
				det_valid = 1'b1;
				ovr_strobe = 1'b1;
			end
		end
		if (!seen) begin
			other_errs++;
			$display("timeout at %0t: no res_valid within 40 cycles of a detection", $time);
		end
		// result cycle over, FSM back in IDLE
		@(negedge clk);
		det_valid = 1'b0;
		ovr_strobe = 1'b0;
		pending = 1'b0;
	endtask

	task automatic frame_clear();
		@(negedge clk);
		ready_new_frame = 1'b1;
		model_clear();
		@(negedge clk);
		ready_new_frame = 1'b0;
	endtask

	// --------------------
	// main sequence
	// --------------------

	initial begin
		feature_t base;
		feature_t tie_feat;
		int i;
		int sel;
		reset_N = 1'b0;
		det_valid = 1'b0;
		det_feature = '0;
		ready_new_frame = 1'b0;
		model_clear();
		void'($urandom(66));
		repeat (3) @(negedge clk);
		reset_N = 1'b1;
		repeat (5) @(negedge clk);
		// first detection on an empty table
		detect(feature_t'($urandom()), 0);
		// hit, then the refreshed feature again
		base = near_copy(mdl_rows[0]);
		detect(base, 0);
		detect(base, 0);
		// fill the table, then one more is dropped
		i = 0;
		while (mdl_count < `MAX_ROWS && i < 40) begin
			detect(feature_t'($urandom()), 0);
			i++;
		end
		detect(feature_t'($urandom()), 0);
		detect(near_copy(mdl_rows[3]), 0);
		// busy strobe during a full scan
		detect(near_copy(mdl_rows[5]), 2);
		repeat (4) @(negedge clk);
		frame_clear();
		// two rows 40 apart, probe halfway between
		base = {8'd80, 8'd70, 8'd60, 8'd50};
		detect(base, 0);
		tie_feat = base;
		tie_feat[0] = base[0] + 8'd40;
		detect(tie_feat, 0);
		tie_feat[0] = base[0] + 8'd20;
		detect(tie_feat, 0);
		// random mix
		for (int k = 0; k < 40; k++) begin
			sel = $urandom_range(0, 9);
			if (sel == 0) begin
				frame_clear();
			end else if (sel < 5 && mdl_count > 0) begin
				base = near_copy(mdl_rows[$urandom_range(0, mdl_count - 1)]);
				detect(base, ($urandom_range(0, 3) == 0) ? 3 : 0);
			end else begin
				detect(feature_t'($urandom()), 0);
			end
		end
		repeat (5) @(negedge clk);
		$display("error counts: mismatch=%0d other=%0d", mismatch_errs, other_errs);
		if (mismatch_errs == 0 && other_errs == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: rtl/feature_scoreboard.sv
`timescale 1ns/1ns
`include "tracker_params.svh"

module feature_scoreboard (
	input  logic                  clk,
	input  logic                  reset_N,
	// frame boundary from core
	input  logic                  ready_new_frame,
	// sequencer side
	input  logic                  we,
	input  tracker_pkg::row_t     addr,
	input  tracker_pkg::feature_t data_in,
	// towards lane engines
	output tracker_pkg::feature_t data_out
);

	import tracker_pkg::*;

	// --------------------
	// row storage
	// --------------------

	// one stored feature per tracked object
	feature_t feat_rows [`MAX_ROWS];

	// whole table wiped on new frame
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			feat_rows <= '{default: '0};
		end else if (ready_new_frame) begin
			feat_rows <= '{default: '0};
		end else if (we) begin
			feat_rows[addr] <= data_in;
		end
	end

	// --------------------
	// read port
	// --------------------

	// same address as the write, no read latency
	assign data_out = feat_rows[addr];

endmodule

// File: rtl/lane_distance_pe.sv
`timescale 1ns/1ns

module lane_distance_pe (
	input  logic               clk,
	input  logic               reset_N,
	// lane of the latched detection
	input  tracker_pkg::lane_t det_lane,
	// same lane of the row being scanned
	input  tracker_pkg::lane_t row_lane,
	// registered distance, one cycle behind the inputs
	output tracker_pkg::lane_t lane_dist
);

	import tracker_pkg::*;

	// --------------------
	// absolute difference
	// --------------------

	lane_t abs_diff;

	// unsigned lanes, subtract the smaller from the larger
	always_comb begin
		if (det_lane >= row_lane) begin
			abs_diff = det_lane - row_lane;
		end else begin
			abs_diff = row_lane - det_lane;
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			lane_dist <= '0;
		end else begin
			lane_dist <= abs_diff;
		end
	end

endmodule

// File: rtl/match_selector.sv
`timescale 1ns/1ns
`include "tracker_params.svh"

module match_selector (
	input  logic                clk,
	input  logic                reset_N,
	// scan markers already aligned with lane_dist
	input  logic                scan_first,
	input  logic                scan_last,
	input  tracker_pkg::row_t   scan_row,
	// one registered distance per lane
	input  tracker_pkg::lane_t  lane_dist [`FEAT_LANES],
	// best match over the scan
	output logic                sel_done,
	output logic                sel_hit,
	output tracker_pkg::row_t   sel_row,
	output tracker_pkg::score_t sel_score
);

	import tracker_pkg::*;

	// --------------------
	// lane sum
	// --------------------

	score_t lane_sum;
	score_t min_score;
	row_t   min_row;
	score_t cand_score;
	row_t   cand_row;

	always_comb begin
		lane_sum = '0;
		for (int i = 0; i < `FEAT_LANES; i++) begin
			lane_sum = lane_sum + score_t'(lane_dist[i]);
		end
	end

	// --------------------
	// running minimum
	// --------------------

	// strictly smaller only so the lowest row wins a tie
	always_comb begin
		if (scan_first || (lane_sum < min_score)) begin
			cand_score = lane_sum;
			cand_row   = scan_row;
		end else begin
			cand_score = min_score;
			cand_row   = min_row;
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			sel_done <= 1'b0;
		end else begin
			sel_done <= scan_last;
		end
	end

	always_ff @(posedge clk) begin
		// scan_first restarts the minimum at each scan
		min_score <= cand_score;
		min_row   <= cand_row;
		// last sample already folded into the candidate
		if (scan_last) begin
			sel_score <= cand_score;
			sel_row   <= cand_row;
			sel_hit   <= (cand_score <= score_t'(`MATCH_THRESH));
		end
	end

endmodule

// File: rtl/registration_top.sv
`timescale 1ns/1ns
`include "tracker_params.svh"

module registration_top (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  det_valid,
	input  tracker_pkg::feature_t det_feature,
	input  logic                  ready_new_frame,
	output logic                  res_valid,
	output tracker_pkg::row_t     res_id,
	output logic                  res_new,
	output logic                  res_drop,
	output tracker_pkg::score_t   res_score,
	output logic                  det_overrun
);

	import tracker_pkg::*;

	// --------------------
	// internal wires
	// --------------------

	// scoreboard port
	row_t     sb_addr;
	logic     sb_we;
	feature_t sb_data;
	feature_t det_latched;

	// scan markers
	logic     scan_first;
	logic     scan_last;
	row_t     scan_row;

	// engine outputs
	lane_t    lane_dist [`FEAT_LANES];

	// selector result
	logic     sel_done;
	logic     sel_hit;
	row_t     sel_row;
	score_t   sel_score;

	// --------------------
	// instances
	// --------------------

	feature_scoreboard u_scoreboard (
		.clk             (clk),
		.reset_N         (reset_N),
		.ready_new_frame (ready_new_frame),
		.we              (sb_we),
		.addr            (sb_addr),
		.data_in         (det_latched),
		.data_out        (sb_data)
	);

	scan_sequencer u_sequencer (
		.clk             (clk),
		.reset_N         (reset_N),
		.det_valid       (det_valid),
		.det_feature     (det_feature),
		.ready_new_frame (ready_new_frame),
		.sel_done        (sel_done),
		.sel_hit         (sel_hit),
		.sel_row         (sel_row),
		.sel_score       (sel_score),
		.sb_addr         (sb_addr),
		.sb_we           (sb_we),
		.det_latched     (det_latched),
		.scan_first      (scan_first),
		.scan_last       (scan_last),
		.scan_row        (scan_row),
		.res_valid       (res_valid),
		.res_id          (res_id),
		.res_new         (res_new),
		.res_drop        (res_drop),
		.res_score       (res_score),
		.det_overrun     (det_overrun)
	);

	// one engine per lane
	for (genvar i = 0; i < `FEAT_LANES; i++) begin : g_lane
		lane_distance_pe u_pe (
			.clk       (clk),
			.reset_N   (reset_N),
			.det_lane  (det_latched[i]),
			.row_lane  (sb_data[i]),
			.lane_dist (lane_dist[i])
		);
	end

	match_selector u_selector (
		.clk        (clk),
		.reset_N    (reset_N),
		.scan_first (scan_first),
		.scan_last  (scan_last),
		.scan_row   (scan_row),
		.lane_dist  (lane_dist),
		.sel_done   (sel_done),
		.sel_hit    (sel_hit),
		.sel_row    (sel_row),
		.sel_score  (sel_score)
	);

endmodule

// File: rtl/scan_sequencer.sv
`timescale 1ns/1ns
`include "tracker_params.svh"

module scan_sequencer (
	input  logic                  clk,
	input  logic                  reset_N,
	// detection input
	input  logic                  det_valid,
	input  tracker_pkg::feature_t det_feature,
	input  logic                  ready_new_frame,
	// match selector result
	input  logic                  sel_done,
	input  logic                  sel_hit,
	input  tracker_pkg::row_t     sel_row,
	input  tracker_pkg::score_t   sel_score,
	// scoreboard access
	output tracker_pkg::row_t     sb_addr,
	output logic                  sb_we,
	output tracker_pkg::feature_t det_latched,
	// scan markers, aligned with engine outputs
	output logic                  scan_first,
	output logic                  scan_last,
	output tracker_pkg::row_t     scan_row,
	// result report
	output logic                  res_valid,
	output tracker_pkg::row_t     res_id,
	output logic                  res_new,
	output logic                  res_drop,
	output tracker_pkg::score_t   res_score,
	output logic                  det_overrun
);

	import tracker_pkg::*;

	// --------------------
	// state
	// --------------------

	seq_state_t       state;
	// occupied rows, one extra bit so a full table is representable
	logic [`ROW_W:0]  row_count;
	row_t             scan_idx;

	logic             table_full;
	logic             scan_first_c;
	logic             scan_last_c;

	// outcome chosen on sel_done
	row_t             nxt_id;
	logic             nxt_new;
	logic             nxt_drop;

	assign table_full = (row_count == (`ROW_W+1)'(`MAX_ROWS));

	// markers before the one-cycle delay
	assign scan_first_c = (state == SCAN) && (scan_idx == '0);
	assign scan_last_c  = (state == SCAN) && ({1'b0, scan_idx} == row_count - 1'b1);

	// --------------------
	// outcome decision
	// --------------------

	always_comb begin
		nxt_id   = sel_row;
		nxt_new  = 1'b0;
		nxt_drop = 1'b0;
		if (!sel_hit) begin
			// no free row, report nearest row id with drop set
			if (table_full) begin
				nxt_drop = 1'b1;
			end else begin
				// next free row sits right after the occupied ones
				nxt_id  = row_count[`ROW_W-1:0];
				nxt_new = 1'b1;
			end
		end
	end

	// --------------------
	// control FSM
	// --------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state       <= IDLE;
			row_count   <= '0;
			scan_idx    <= '0;
			scan_first  <= 1'b0;
			scan_last   <= 1'b0;
			scan_row    <= '0;
			res_valid   <= 1'b0;
			res_new     <= 1'b0;
			res_drop    <= 1'b0;
			det_overrun <= 1'b0;
		end else begin
			res_valid   <= 1'b0;
			// strobe outside IDLE is dropped and flagged
			det_overrun <= det_valid && (state != IDLE);
			// delay markers to meet the registered lane distances
			scan_first  <= scan_first_c;
			scan_last   <= scan_last_c;
			scan_row    <= scan_idx;
			case (state)
				IDLE: begin
					// frame clear wins over a same-cycle detection
					if (ready_new_frame) begin
						row_count <= '0;
					end else if (det_valid) begin
						scan_idx <= '0;
						if (row_count == '0) begin
							// empty table, straight to write-back of row 0
							state     <= WRITE;
							res_valid <= 1'b1;
							res_new   <= 1'b1;
							res_drop  <= 1'b0;
						end else begin
							state <= SCAN;
						end
					end
				end
				SCAN: begin
					if (scan_last_c) begin
						state <= DRAIN;
					end else begin
						scan_idx <= scan_idx + 1'b1;
					end
				end
				DRAIN: begin
					// engine and selector pipeline still emptying
					if (sel_done) begin
						state     <= WRITE;
						res_valid <= 1'b1;
						res_new   <= nxt_new;
						res_drop  <= nxt_drop;
					end
				end
				WRITE: begin
					if (res_new) begin
						row_count <= row_count + 1'b1;
					end
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// --------------------
	// payload registers
	// --------------------

	always_ff @(posedge clk) begin
		if ((state == IDLE) && det_valid && !ready_new_frame) begin
			det_latched <= det_feature;
			// no rows to compare against
			res_id      <= '0;
			res_score   <= '0;
		end
		if ((state == DRAIN) && sel_done) begin
			res_id    <= nxt_id;
			res_score <= sel_score;
		end
	end

	// --------------------
	// scoreboard access
	// --------------------

	// write-back uses the reported id, scan uses the walk index
	assign sb_addr = (state == WRITE) ? res_id : scan_idx;
	// a drop leaves the table untouched
	assign sb_we   = (state == WRITE) && !res_drop;

endmodule

// File: rtl/tracker_params.svh
`ifndef TRACKER_PARAMS_SVH
`define TRACKER_PARAMS_SVH

// --------------------
// feature word shape
// --------------------

// lanes per feature word
`define FEAT_LANES 4

// bits per lane, unsigned
`define LANE_W 8

// --------------------
// scoreboard sizing
// --------------------

// rows held within one frame
`define MAX_ROWS 8

// row index width, log2 of MAX_ROWS
`define ROW_W 3

// summed distance, four lanes of 8 bits max 1020
`define SCORE_W 10

// highest summed distance still counted as the same object
`define MATCH_THRESH 24

`endif

// File: rtl/tracker_pkg.sv
`include "tracker_params.svh"

package tracker_pkg;

	// --------------------
	// datapath types
	// --------------------

	// one unsigned lane
	typedef logic [`LANE_W-1:0] lane_t;

	// whole feature word
	// lane 0 sits in the low bits
	typedef lane_t [`FEAT_LANES-1:0] feature_t;

	// scoreboard row index
	typedef logic [`ROW_W-1:0] row_t;

	// summed lane distance
	typedef logic [`SCORE_W-1:0] score_t;

	// --------------------
	// sequencer FSM
	// --------------------

	// IDLE waits for a strobe, SCAN drives read addresses,
	// DRAIN waits on the selector, WRITE does the write-back
	typedef enum logic [1:0] {IDLE, SCAN, DRAIN, WRITE} seq_state_t;

endpackage
